// File: pio_params.svh
`ifndef PIO_PARAMS_SVH
`define PIO_PARAMS_SVH

// flag pins and bus word.
`define PIO_FLAGS 12
`define PIO_WORD 16

// low flag byte sits in word bits 7:0.
`define PIO_LO_W 8

`define PIO_ADDR_W 2

// register map.
`define PIO_A_PMASK 2'd0
`define PIO_A_PINT 2'd1
`define PIO_A_PFTYPE 2'd2
`define PIO_A_PFDATA 2'd3

`endif

// File: pioPkg.sv
`include "pio_params.svh"

package pioPkg;

  // one bit per flag pin.
  typedef logic [`PIO_FLAGS-1:0] pioFlags;

  typedef logic [`PIO_ADDR_W-1:0] pioAddr;

  // flag bits 11:8 in word 15:12, 7:0 in word 7:0.
  typedef struct packed {
    logic [`PIO_FLAGS-`PIO_LO_W-1:0]          flagHi;
    logic [`PIO_WORD-`PIO_FLAGS-1:0]          pad;
    logic [`PIO_LO_W-1:0]                     flagLo;
  } pioWordFields;

  // bus word, seen whole or as flag fields.
  typedef union packed {
    logic [`PIO_WORD-1:0] raw;
    pioWordFields         fields;
  } pioWord;

  // single-cycle strobes, no back-pressure.
  typedef struct packed {
    logic   wrStb;
    logic   rdStb;
    pioAddr addr;
    pioWord wdata;
  } pioBusReq;

endpackage

// File: pioRegs.sv
`timescale 1ns/10ps
`include "pio_params.svh"

module pioRegs import pioPkg::*;
(
  input  logic     PIOCLK0,
  input  logic     T_RST,
  input  pioBusReq busReq,
  input  pioFlags  pInt,
  input  pioFlags  pfData,
  output pioFlags  pMask,
  output pioFlags  pfType,
  output logic     pintWe,
  output logic     pfdataWe,
  output pioFlags  wrFlags,
  output pioWord   rdData,
  output logic     rdValid
);

  pioFlags rdSel;
  pioWord  rdWord;
  logic    maskWe;
  logic    typeWe;

  // unpack the write word, pad nibble dropped.
  assign wrFlags = {busReq.wdata.fields.flagHi, busReq.wdata.fields.flagLo};

  assign maskWe   = busReq.wrStb && (busReq.addr == `PIO_A_PMASK);
  assign typeWe   = busReq.wrStb && (busReq.addr == `PIO_A_PFTYPE);
  assign pintWe   = busReq.wrStb && (busReq.addr == `PIO_A_PINT);
  assign pfdataWe = busReq.wrStb && (busReq.addr == `PIO_A_PFDATA);

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      pMask  <= '0;
      pfType <= '0;
    end
    else
    begin
      if (maskWe)
      begin
        pMask <= wrFlags;
      end
      if (typeWe)
      begin
        pfType <= wrFlags; // 1 = output.
      end
    end
  end

  always_comb
  begin
    case (busReq.addr)
      `PIO_A_PMASK:  rdSel = pMask;
      `PIO_A_PINT:   rdSel = pInt;
      `PIO_A_PFTYPE: rdSel = pfType;
      default:       rdSel = pfData;
    endcase
  end

  // pack into word layout, 11:8 read as zero.
  always_comb
  begin
    rdWord.raw           = '0;
    rdWord.fields.flagHi = rdSel[`PIO_FLAGS-1:`PIO_LO_W];
    rdWord.fields.flagLo = rdSel[`PIO_LO_W-1:0];
  end

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      rdValid <= 1'b0;
    end
    else
    begin
      rdValid <= busReq.rdStb; // one cycle read latency.
    end
  end

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      rdData <= '0;
    end
    else if (busReq.rdStb)
    begin
      rdData <= rdWord;
    end
  end

  // a strobe must come with a clean address.
  addrKnown: assert property (
    @(posedge PIOCLK0) disable iff (T_RST)
    (busReq.wrStb || busReq.rdStb) |-> !$isunknown(busReq.addr)
  );

endmodule

// File: pioEdgeDetect.sv
`timescale 1ns/10ps

module pioEdgeDetect import pioPkg::*;
(
  input  logic    PIOCLK0,
  input  logic    T_RST,
  input  pioFlags pioIn,
  output pioFlags pinLevel,
  output pioFlags pinChange
);

  pioFlags pinSamp;
  pioFlags levelDly;
  pioFlags bothHi;
  pioFlags eitherHi;
  pioFlags levelNext;

  // previous pin sample.
  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      pinSamp <= '0;
    end
    else
    begin
      pinSamp <= pioIn;
    end
  end

  assign bothHi   = pioIn & pinSamp;
  assign eitherHi = pioIn | pinSamp;

  // level only moves when both samples agree on the new value.
  assign levelNext = (pinLevel & eitherHi) | (~pinLevel & bothHi);

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      pinLevel <= '0;
      levelDly <= '0;
    end
    else
    begin
      pinLevel <= levelNext;
      levelDly <= pinLevel; // one cycle behind.
    end
  end

  assign pinChange = pinLevel ^ levelDly;

  // a change pulse needs a real level step.
  changeIsStep: assert property (
    @(posedge PIOCLK0) disable iff (T_RST)
    (pinChange & ~(pinLevel ^ $past(pinLevel))) == '0
  );

endmodule

// File: pioFlagData.sv
`timescale 1ns/10ps

module pioFlagData import pioPkg::*;
(
  input  logic    PIOCLK0,
  input  logic    T_RST,
  input  pioFlags pfType,
  input  pioFlags pinLevel,
  input  logic    pfdataWe,
  input  pioFlags wrFlags,
  output pioFlags pfData
);

  pioFlags outNext;
  pioFlags dataNext;

  // output pins take the write, else hold.
  assign outNext = pfdataWe ? wrFlags : pfData;

  always_comb
  begin
    for (int i = 0; i < $bits(pioFlags); i++)
    begin
      if (pfType[i])
      begin
        dataNext[i] = outNext[i];
      end
      else
      begin
        dataNext[i] = pinLevel[i]; // input pin follows filter.
      end
    end
  end

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      pfData <= '0;
    end
    else
    begin
      pfData <= dataNext;
    end
  end

endmodule

// File: pioIntCtrl.sv
`timescale 1ns/10ps

module pioIntCtrl import pioPkg::*;
(
  input  logic    PIOCLK0,
  input  logic    T_RST,
  input  pioFlags pinChange,
  input  pioFlags pfType,
  input  pioFlags pMask,
  input  logic    pintWe,
  input  pioFlags wrFlags,
  output pioFlags pInt,
  output logic    pioIntn
);

  pioFlags intSet;

  // only masked-in input pins raise a flag.
  assign intSet = pinChange & ~pfType & pMask;

  always_ff @(posedge PIOCLK0 or posedge T_RST)
  begin
    if (T_RST)
    begin
      pInt <= '0;
    end
    else if (pintWe)
    begin
      pInt <= wrFlags; // software write wins over a new set.
    end
    else
    begin
      pInt <= pInt | intSet;
    end
  end

  assign pioIntn = ~|(pMask & pInt);

  // no stale request out of reset.
  intIdleAfterReset: assert property (
    @(posedge PIOCLK0)
    $fell(T_RST) |-> pioIntn
  );

endmodule

// File: pioTop.sv
`timescale 1ns/10ps

module pioTop import pioPkg::*;
(
  input  logic     PIOCLK0,
  input  logic     T_RST,
  input  pioBusReq busReq,
  input  pioFlags  pioIn,
  output pioWord   rdData,
  output logic     rdValid,
  output pioFlags  pioOut,
  output pioFlags  pioEn,
  output logic     pioIntn
);

  pioFlags pMask;
  pioFlags pfType;
  pioFlags pInt;
  pioFlags pfData;
  pioFlags wrFlags;
  pioFlags pinLevel;
  pioFlags pinChange;
  logic    pintWe;
  logic    pfdataWe;

  pioRegs uRegs (
    .PIOCLK0  (PIOCLK0),
    .T_RST    (T_RST),
    .busReq   (busReq),
    .pInt     (pInt),
    .pfData   (pfData),
    .pMask    (pMask),
    .pfType   (pfType),
    .pintWe   (pintWe),
    .pfdataWe (pfdataWe),
    .wrFlags  (wrFlags),
    .rdData   (rdData),
    .rdValid  (rdValid)
  );

  pioEdgeDetect uEdge (
    .PIOCLK0   (PIOCLK0),
    .T_RST     (T_RST),
    .pioIn     (pioIn),
    .pinLevel  (pinLevel),
    .pinChange (pinChange)
  );

  pioFlagData uData (
    .PIOCLK0  (PIOCLK0),
    .T_RST    (T_RST),
    .pfType   (pfType),
    .pinLevel (pinLevel),
    .pfdataWe (pfdataWe),
    .wrFlags  (wrFlags),
    .pfData   (pfData)
  );

  pioIntCtrl uInt (
    .PIOCLK0   (PIOCLK0),
    .T_RST     (T_RST),
    .pinChange (pinChange),
    .pfType    (pfType),
    .pMask     (pMask),
    .pintWe    (pintWe),
    .wrFlags   (wrFlags),
    .pInt      (pInt),
    .pioIntn   (pioIntn)
  );

  assign pioOut = pfData;
  assign pioEn  = pfType; // 1 = pin driven.

endmodule

// File: tbPio.sv
`timescale 1ns/10ps
`include "pio_params.svh"

module tbPio import pioPkg::*;
();

  localparam int TIMEOUT = 20;
  localparam logic [2:0] OP_WR = 3'd0;
  localparam logic [2:0] OP_RD = 3'd1;
  localparam logic [2:0] OP_PIN = 3'd2;
  localparam logic [2:0] OP_GLITCH = 3'd3;
  localparam logic [2:0] OP_CHK = 3'd4;

  typedef struct packed {
    logic [2:0]           op;
    logic [2:0]           test;
    pioAddr               addr;
    logic [`PIO_WORD-1:0] data;
    logic [31:0]          exp;
  } stepT;

  logic     PIOCLK0;
  logic     T_RST;
  pioBusReq busReq;
  pioFlags  pioIn;
  pioWord   rdData;
  logic     rdValid;
  pioFlags  pioOut;
  pioFlags  pioEn;
  logic     pioIntn;

  stepT     steps[$];
  pioFlags  mMask;
  pioFlags  mType;
  pioFlags  mInt;
  pioFlags  mData;
  pioFlags  mLevel;
  int       errors;
  int       checks;
  int       testErr[5];
  string    testName[5];

  pioTop dut (
    .PIOCLK0 (PIOCLK0),
    .T_RST   (T_RST),
    .busReq  (busReq),
    .pioIn   (pioIn),
    .rdData  (rdData),
    .rdValid (rdValid),
    .pioOut  (pioOut),
    .pioEn   (pioEn),
    .pioIntn (pioIntn)
  );

  initial PIOCLK0 = 1'b0;
  always #50 PIOCLK0 = ~PIOCLK0;

  // flag 11:8 to word 15:12, flag 7:0 to word 7:0.
  function automatic logic [15:0] packWord(input pioFlags f);
    return {f[11:8], 4'b0000, f[7:0]};
  endfunction

  function automatic pioFlags wordFlags(input logic [15:0] w);
    return {w[15:12], w[7:0]};
  endfunction

  // pushes one step and advances the reference model.
  task automatic addStep(input logic [2:0] op, input int test, input int addr,
                         input logic [31:0] data);
    stepT    s;
    pioFlags f;
    pioFlags pinVal;
    s = {op, 3'(test), pioAddr'(addr), data[15:0], 32'd0};
    f = wordFlags(data[15:0]);
    pinVal = data[11:0];
    case (op)
      OP_WR:
      begin
        case (addr)
          `PIO_A_PMASK:  mMask = f;
          `PIO_A_PINT:   mInt = f;
          `PIO_A_PFTYPE: mType = f;
          default:       mData = (f & mType) | (mData & ~mType);
        endcase
      end
      OP_RD:
      begin
        case (addr)
          `PIO_A_PMASK:  s.exp = {16'd0, packWord(mMask)};
          `PIO_A_PINT:   s.exp = {16'd0, packWord(mInt)};
          `PIO_A_PFTYPE: s.exp = {16'd0, packWord(mType)};
          default:       s.exp = {16'd0, packWord(mData)};
        endcase
      end
      OP_PIN:
      begin
        mInt = mInt | ((mLevel ^ pinVal) & ~mType & mMask); // masked-in inputs only.
        mLevel = pinVal;
      end
      OP_CHK: s.exp = {6'd0, 1'b0, ~|(mMask & mInt), mType, mData};
      default: ;
    endcase
    mData = (mData & mType) | (mLevel & ~mType); // inputs follow filtered level.
    steps.push_back(s);
  endtask

  task automatic buildTable();
    addStep(OP_CHK, 0, 0, 0);
    for (int a = 0; a < 4; a++)
      addStep(OP_RD, 0, a, 0);
    addStep(OP_WR, 1, `PIO_A_PMASK, $urandom);
    addStep(OP_RD, 1, `PIO_A_PMASK, 0);
    addStep(OP_WR, 1, `PIO_A_PFTYPE, $urandom);
    addStep(OP_RD, 1, `PIO_A_PFTYPE, 0);
    addStep(OP_WR, 1, `PIO_A_PINT, $urandom);
    addStep(OP_RD, 1, `PIO_A_PINT, 0);
    addStep(OP_CHK, 1, 0, 0);
    addStep(OP_WR, 2, `PIO_A_PFTYPE, 32'hffff); // all pins driven.
    addStep(OP_WR, 2, `PIO_A_PFDATA, $urandom);
    addStep(OP_CHK, 2, 0, 0);
    addStep(OP_RD, 2, `PIO_A_PFDATA, 0);
    addStep(OP_WR, 2, `PIO_A_PFTYPE, $urandom);
    addStep(OP_PIN, 2, 0, $urandom);
    addStep(OP_WR, 2, `PIO_A_PFDATA, $urandom);
    addStep(OP_CHK, 2, 0, 0);
    addStep(OP_RD, 2, `PIO_A_PFDATA, 0);
    addStep(OP_WR, 3, `PIO_A_PFTYPE, 0);
    for (int i = 0; i < 4; i++)
    begin
      addStep(OP_PIN, 3, 0, $urandom);
      addStep(OP_CHK, 3, 0, 0);
      addStep(OP_GLITCH, 3, 0, $urandom);
      addStep(OP_RD, 3, `PIO_A_PFDATA, 0);
    end
    addStep(OP_WR, 4, `PIO_A_PINT, 0);
    for (int i = 0; i < 4; i++)
    begin
      addStep(OP_WR, 4, `PIO_A_PMASK, $urandom);
      addStep(OP_WR, 4, `PIO_A_PFTYPE, $urandom);
      addStep(OP_PIN, 4, 0, $urandom);
      addStep(OP_CHK, 4, 0, 0);
      addStep(OP_RD, 4, `PIO_A_PINT, 0);
      addStep(OP_WR, 4, `PIO_A_PINT, 0);
      addStep(OP_CHK, 4, 0, 0);
    end
  endtask

  task automatic checkValue(input int test, input logic [31:0] got, input logic [31:0] exp,
                            input string what);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      testErr[test]++;
      $display("error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // one-cycle strobe, notes rdValid before the next edge.
  task automatic busCycle(input pioBusReq req, output logic early);
    @(posedge PIOCLK0);
    busReq <= req;
    @(negedge PIOCLK0);
    early = rdValid;
    @(posedge PIOCLK0);
    busReq <= '0;
  endtask

  task automatic runStep(input stepT s);
    logic    early;
    int      lat;
    pioFlags saved;
    case (s.op)
      OP_WR:
      begin
        busCycle({1'b1, 1'b0, s.addr, s.data}, early);
        @(posedge PIOCLK0); // let dependent pins settle.
      end
      OP_RD:
      begin
        busCycle({1'b0, 1'b1, s.addr, 16'd0}, early);
        lat = 0;
        @(negedge PIOCLK0);
        while (!rdValid && lat < TIMEOUT)
        begin
          @(negedge PIOCLK0);
          lat++;
        end
        if (!rdValid)
        begin
          errors++;
          testErr[s.test]++;
          $display("read of register %0d timed out: rdValid never went high", s.addr);
        end
        else
        begin
          checkValue(s.test, {31'd0, early || lat != 0}, 32'd0, "read latency off by");
          checkValue(s.test, {16'd0, rdData.raw}, s.exp, "read data");
        end
      end
      OP_PIN:
      begin
        @(posedge PIOCLK0);
        pioIn <= s.data[11:0];
        repeat (3) @(posedge PIOCLK0); // filter plus register stage.
      end
      OP_GLITCH:
      begin
        @(posedge PIOCLK0);
        saved = pioIn;
        pioIn <= pioIn ^ s.data[11:0];
        @(posedge PIOCLK0);
        pioIn <= saved;
        repeat (3) @(posedge PIOCLK0);
      end
      default:
      begin
        @(negedge PIOCLK0);
        checkValue(s.test, {6'd0, rdValid, pioIntn, pioEn, pioOut}, s.exp, "pin outputs");
      end
    endcase
  endtask

  task automatic reportTest(input int t);
    if (testErr[t] == 0)
      $display("test %0d %s: passed", t, testName[t]);
    else
      $display("test %0d %s: %0d errors", t, testName[t], testErr[t]);
  endtask

  initial
  begin
    int cur;
    testName = '{"reset", "register access", "output pins", "glitch filter", "interrupts"};
    void'($urandom(32'h6357_8f5b));
    T_RST = 1'b1;
    busReq = '0;
    pioIn = '0;
    errors = 0;
    checks = 0;
    testErr = '{default: 0};
    mMask = '0;
    mType = '0;
    mInt = '0;
    mData = '0;
    mLevel = '0;
    buildTable();
    repeat (10) @(posedge PIOCLK0);
    T_RST <= 1'b0;
    cur = 0;
    foreach (steps[i])
    begin
      if (steps[i].test != cur)
      begin
        reportTest(cur);
        cur = steps[i].test;
      end
      runStep(steps[i]);
    end
    reportTest(cur);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+.
pioPkg.sv
pioRegs.sv
pioEdgeDetect.sv
pioFlagData.sv
pioIntCtrl.sv
pioTop.sv
tbPio.sv

// File: Bender.yml
package:
  name: pio

sources:
  - include_dirs:
      - .
    files:
      - pioPkg.sv
      - pioRegs.sv
      - pioEdgeDetect.sv
      - pioFlagData.sv
      - pioIntCtrl.sv
      - pioTop.sv
  - target: test
    include_dirs:
      - .
    files:
      - tbPio.sv
